// File: compile.f
hdl/gauss_pkg.sv
hdl/matrix_mem.sv
hdl/elim_step.sv
hdl/elim_phase.sv
hdl/gauss_top.sv
test/gauss_props.sv
test/gauss_tb.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
verilator --binary --timing --assert --top-module gauss_tb -f compile.f -o gauss_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/gauss_sim > sim.log 2>&1 || { cat sim.log; echo "simulation stopped with an error"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "testbench reported failure"; exit 1; }
exit 0

// File: test/gauss_tb.sv
// self-checking testbench for gauss_top, applies a case table against a software gf(2) model
module gauss_tb;
  import gauss_pkg::*;

  localparam int TIMEOUT = 20000;  // cycles allowed per phase

  logic              clk;
  logic              rst_n;
  logic              start;
  logic [BLK_W-1:0]  start_block;
  logic              busy;
  logic              done;
  logic [RANK_W-1:0] rank;
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  logic [N-1:0]      data_out;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [N-1:0]      data_in;

  logic [K-1:0] exp_m [L];  // expected matrix, bit c of a row is column c
  int           mrank;      // expected rank from the model

  // source (1 full rank, 2 rank deficient, 3 random), start_block, run, busy writes, rank or -1
  int tbl [8][5] = '{
    '{3, 0, 0, 0, -1},  // load and read back only
    '{1, 0, 1, 0, 8},
    '{2, 0, 1, 0, 4},   // four distinct rows, each twice
    '{3, 2, 1, 0, -1},  // blocks 0 and 1 untouched
    '{3, 1, 1, 0, -1},
    '{3, 0, 1, 0, -1},
    '{3, 0, 1, 0, -1},
    '{3, 0, 1, 1, -1}   // junk writes during the phase
  };
  logic [K-1:0] dup_rows [4] = '{16'h8001, 16'h4012, 16'h2104, 16'h1e48};  // column 5 all zero

  gauss_top gauss_top_i (.*);

  bind elim_phase gauss_props gauss_props_i (
    .clk(clk), .rst_n(rst_n), .start(start), .busy(busy),
    .done(done), .step_start(step_start), .step_done(step_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("** FAIL **");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_word(input logic [N-1:0] got, input logic [N-1:0] exp, input int addr);
    if (got !== exp) begin
      $display("MISMATCH at %0t: word %0d read %h, expected %h", $time, addr, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_rank(input logic [RANK_W-1:0] got, input logic [RANK_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: rank %0d, expected %0d", $time, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: busy %b after done, expected %b", $time, got, exp);
      stop_on_error();
    end
  endtask

  task automatic fill_model(input int src);
    for (int r = 0; r < L; r++) begin
      case (src)
        1: exp_m[r] = {8'(r * 91 + 33), 8'(8'hff >> (7 - r))};  // bits 0..r set, triangular
        2: exp_m[r] = dup_rows[r % 4];
        default: exp_m[r] = K'($urandom());
      endcase
    end
  endtask

  // same procedure as the engine, column by column from the start block
  task automatic reduce_model(input int sb);
    logic [K-1:0] tmp;
    int           piv;
    mrank = 0;
    for (int c = sb * N; c < K; c++) begin
      piv = -1;
      for (int r = L - 1; r >= mrank; r--) begin
        if (exp_m[r][c])
          piv = r;  // lowest row wins
      end
      if (piv >= 0) begin
        tmp          = exp_m[piv];
        exp_m[piv]   = exp_m[mrank];
        exp_m[mrank] = tmp;
        for (int r = 0; r < L; r++) begin
          if (r != mrank && exp_m[r][c])
            exp_m[r] = exp_m[r] ^ exp_m[mrank];  // gf(2) row add
        end
        mrank++;
      end
    end
  endtask

  task automatic load_matrix();
    for (int r = 0; r < L; r++) begin
      for (int b = 0; b < BLOCKS; b++) begin
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= ADDR_W'(r * BLOCKS + b);
        data_in <= exp_m[r][b*N +: N];
      end
    end
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  // new address every cycle, each word checked while the next address is already out
  task automatic read_matrix();
    int r;
    int b;
    for (int a = 0; a <= L * BLOCKS; a++) begin
      @(posedge clk);
      wr_en   <= 1'b0;
      rd_en   <= (a < L * BLOCKS);
      rd_addr <= ADDR_W'(a);
      @(negedge clk);
      if (a > 0) begin
        r = (a - 1) / BLOCKS;  // word read on the edge before
        b = (a - 1) % BLOCKS;
        check_word(data_out, exp_m[r][b*N +: N], a - 1);
      end
    end
  endtask

  task automatic pulse_start(input logic [BLK_W-1:0] sb);
    @(posedge clk);
    start       <= 1'b1;
    start_block <= sb;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done(input bit junk);
    int cycles;
    cycles = 0;
    while (done !== 1'b1) begin
      @(posedge clk);
      wr_en   <= junk && cycles < 6;  // early in the phase, engine owns memory
      wr_addr <= ADDR_W'($urandom());
      data_in <= N'($urandom());
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: no done pulse within %0d cycles after start", TIMEOUT);
        stop_on_error();
      end
    end
    check_busy(busy, 1'b0);
  endtask

  initial begin
    void'($urandom(32'hf7f418bc));
    rst_n       <= 1'b0;
    start       <= 1'b0;
    start_block <= '0;
    rd_en       <= 1'b0;
    rd_addr     <= '0;
    wr_en       <= 1'b0;
    wr_addr     <= '0;
    data_in     <= '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      fill_model(tbl[i][0]);
      load_matrix();
      if (tbl[i][2] != 0) begin
        pulse_start(BLK_W'(tbl[i][1]));
        wait_done(tbl[i][3] != 0);
        reduce_model(tbl[i][1]);
        check_rank(rank, RANK_W'(mrank));
        if (tbl[i][4] >= 0)
          check_rank(rank, RANK_W'(tbl[i][4]));  // hand-derived rank
      end
      read_matrix();
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// File: test/gauss_props.sv
// protocol assertions on the phase controller, bound into elim_phase from the testbench
module gauss_props (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic busy,
  input logic done,
  input logic step_start,
  input logic step_done
);

  logic in_step;  // step_start seen, step_done not yet

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      in_step <= 1'b0;
    else if (step_start)
      in_step <= 1'b1;
    else if (step_done)
      in_step <= 1'b0;
  end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done held high for more than one cycle");

  // next step may only start once the running one has reported
  no_overlap: assert property (@(posedge clk) disable iff (!rst_n) in_step |-> !step_start)
    else $error("step_start issued while a step was still running");

  idle_holds: assert property (@(posedge clk) disable iff (!rst_n) (!busy && !start) |=> !busy)
    else $error("busy rose without a start");

endmodule

// File: hdl/gauss_top.sv
// top of the gf(2) gaussian elimination core, load the matrix while idle and then pulse start
module gauss_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic [gauss_pkg::BLK_W-1:0]  start_block,
  output logic                         busy,
  output logic                         done,
  output logic [gauss_pkg::RANK_W-1:0] rank,
  input  logic                         rd_en,
  input  logic [gauss_pkg::ADDR_W-1:0] rd_addr,
  output logic [gauss_pkg::N-1:0]      data_out,
  input  logic                         wr_en,
  input  logic [gauss_pkg::ADDR_W-1:0] wr_addr,
  input  logic [gauss_pkg::N-1:0]      data_in
);
  import gauss_pkg::*;

  logic              step_start;
  logic              step_done;
  logic              first_step;
  logic [BLK_W-1:0]  col_block;
  logic              eng_rd;
  logic              eng_wr;
  logic [ADDR_W-1:0] eng_addr;
  logic [N-1:0]      eng_wdata;
  logic [N-1:0]      eng_rdata;

  elim_phase elim_phase_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .start_block(start_block),
    .busy       (busy),
    .done       (done),
    .step_start (step_start),
    .col_block  (col_block),
    .first_step (first_step),
    .step_done  (step_done)
  );

  elim_step elim_step_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .step_start(step_start),
    .col_block (col_block),
    .first_step(first_step),
    .step_done (step_done),
    .rank      (rank),
    .eng_rd    (eng_rd),
    .eng_wr    (eng_wr),
    .eng_addr  (eng_addr),
    .eng_wdata (eng_wdata),
    .eng_rdata (eng_rdata)
  );

  matrix_mem matrix_mem_i (
    .clk      (clk),
    .busy     (busy),
    .rd_en    (rd_en),
    .wr_en    (wr_en),
    .rd_addr  (rd_addr),
    .wr_addr  (wr_addr),
    .data_in  (data_in),
    .data_out (data_out),
    .eng_rd   (eng_rd),
    .eng_wr   (eng_wr),
    .eng_addr (eng_addr),
    .eng_wdata(eng_wdata),
    .eng_rdata(eng_rdata)
  );

endmodule

// File: hdl/elim_phase.sv
// phase controller, runs one elim_step per column block from start_block up to the last block
module elim_phase (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic [gauss_pkg::BLK_W-1:0] start_block,
  output logic                        busy,
  output logic                        done,
  output logic                        step_start,
  output logic [gauss_pkg::BLK_W-1:0] col_block,
  output logic                        first_step,
  input  logic                        step_done
);
  import gauss_pkg::*;

  logic             running;
  logic [BLK_W-1:0] blk_cnt;    // current column block
  logic             last_blk;   // registered, settles long before step_done
  logic             start_ok;
  logic             in_range;
  logic             no_blocks;
  logic             advance;
  logic             end_phase;

  assign start_ok  = start && !running;          // start ignored while busy
  assign in_range  = (start_block < BLK_W'(BLOCKS));
  assign no_blocks = (blk_cnt >= BLK_W'(BLOCKS)); // only from an out of range start
  assign advance   = running && step_done && !last_blk;
  assign end_phase = running && ((step_done && last_blk) || no_blocks);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running    <= 1'b0;
      blk_cnt    <= '0;
      last_blk   <= 1'b0;
      step_start <= 1'b0;
      first_step <= 1'b0;
      done       <= 1'b0;
    end else begin
      last_blk <= (blk_cnt == BLK_W'(BLOCKS - 1));
      done     <= end_phase;  // busy drops on the same edge

      if (start_ok)
        running <= 1'b1;
      else if (end_phase)
        running <= 1'b0;

      if (start_ok)
        blk_cnt <= start_block;
      else if (advance)
        blk_cnt <= blk_cnt + 1'b1;

      step_start <= (start_ok && in_range) || advance;  // one cycle after start or step_done

      if (start_ok)
        first_step <= 1'b1;   // step clears rank
      else if (step_done || end_phase)
        first_step <= 1'b0;
    end
  end

  assign busy      = running;
  assign col_block = blk_cnt;

endmodule

// File: hdl/elim_step.sv
// one column block of gf(2) elimination: pivot search, row swap and row reduction, started by phase
module elim_step (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         step_start,
  input  logic [gauss_pkg::BLK_W-1:0]  col_block,
  input  logic                         first_step,
  output logic                         step_done,
  output logic [gauss_pkg::RANK_W-1:0] rank,
  output logic                         eng_rd,
  output logic                         eng_wr,
  output logic [gauss_pkg::ADDR_W-1:0] eng_addr,
  output logic [gauss_pkg::N-1:0]      eng_wdata,
  input  logic [gauss_pkg::N-1:0]      eng_rdata
);
  import gauss_pkg::*;

  logic [ST_W-1:0]      state;
  logic [$clog2(N)-1:0] col;       // column inside the block
  logic [ROW_W-1:0]     row;       // search row, then reduce target
  logic [ROW_W-1:0]     piv;       // pivot row from search
  logic [BLK_W-1:0]     blk;       // block walk for swap and xor
  logic [N-1:0]         hold;      // rank word in swap, pivot word in xor
  logic [ROW_W-1:0]     rank_row;
  logic                 col_bit;
  logic                 last_blk;
  logic                 last_row;

  function automatic logic [ADDR_W-1:0] word_addr(input logic [ROW_W-1:0] r,
                                                  input logic [BLK_W-1:0] b);
    word_addr = ADDR_W'(r) * ADDR_W'(BLOCKS) + ADDR_W'(b);
  endfunction

  assign rank_row = rank[ROW_W-1:0];  // only used while rank < L
  assign col_bit  = eng_rdata[col];   // read data from previous cycle
  assign last_blk = (blk == BLK_W'(BLOCKS - 1));
  assign last_row = (row == ROW_W'(L - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      col       <= '0;
      row       <= '0;
      piv       <= '0;
      blk       <= '0;
      rank      <= '0;
      step_done <= 1'b0;
    end else begin
      step_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (step_start) begin
            if (first_step)
              rank <= '0;  // new phase
            col   <= '0;
            state <= ST_COL;
          end
        end
        ST_COL: begin
          if (rank == RANK_W'(L)) begin
            state <= ST_NEXT;  // full rank, nothing left to pivot
          end else begin
            row   <= rank_row;
            state <= ST_SRD;
          end
        end
        ST_SRD: state <= ST_SCHK;
        ST_SCHK: begin
          if (col_bit) begin
            piv <= row;
            blk <= '0;
            if (row == rank_row) begin
              row   <= '0;      // already in place
              state <= ST_RSEL;
            end else begin
              state <= ST_WRDA;
            end
          end else if (last_row) begin
            state <= ST_NEXT;   // no pivot in this column
          end else begin
            row   <= row + 1'b1;
            state <= ST_SRD;
          end
        end
        ST_WRDA: state <= ST_WRDB;
        ST_WRDB: state <= ST_WWRA;
        ST_WWRA: state <= ST_WWRB;
        ST_WWRB: begin
          if (last_blk) begin
            row   <= '0;
            state <= ST_RSEL;
          end else begin
            blk   <= blk + 1'b1;
            state <= ST_WRDA;
          end
        end
        ST_RSEL: state <= (row == rank_row) ? ST_RNXT : ST_RCHK;  // pivot row stays
        ST_RCHK: begin
          if (col_bit) begin
            blk   <= '0;
            state <= ST_XRDP;
          end else begin
            state <= ST_RNXT;
          end
        end
        ST_XRDP: state <= ST_XRDT;
        ST_XRDT: state <= ST_XWR;
        ST_XWR: begin
          if (last_blk) begin
            state <= ST_RNXT;
          end else begin
            blk   <= blk + 1'b1;
            state <= ST_XRDP;
          end
        end
        ST_RNXT: begin
          if (last_row) begin
            rank  <= rank + 1'b1;  // column pivoted
            state <= ST_NEXT;
          end else begin
            row   <= row + 1'b1;
            state <= ST_RSEL;
          end
        end
        ST_NEXT: begin
          if (int'(col) == N - 1) begin
            step_done <= 1'b1;
            state     <= ST_IDLE;
          end else begin
            col   <= col + 1'b1;
            state <= ST_COL;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // capture first of two words before the second read lands
  always_ff @(posedge clk) begin
    if (state == ST_WRDB || state == ST_XRDT)
      hold <= eng_rdata;
  end

  always_comb begin
    eng_rd    = 1'b0;
    eng_wr    = 1'b0;
    eng_addr  = '0;
    eng_wdata = '0;
    case (state)
      ST_SRD: begin
        eng_rd   = 1'b1;
        eng_addr = word_addr(row, col_block);
      end
      ST_WRDA: begin
        eng_rd   = 1'b1;
        eng_addr = word_addr(rank_row, blk);
      end
      ST_WRDB: begin
        eng_rd   = 1'b1;
        eng_addr = word_addr(piv, blk);
      end
      ST_WWRA: begin
        eng_wr    = 1'b1;
        eng_addr  = word_addr(rank_row, blk);
        eng_wdata = eng_rdata;  // pivot word into rank row
      end
      ST_WWRB: begin
        eng_wr    = 1'b1;
        eng_addr  = word_addr(piv, blk);
        eng_wdata = hold;       // old rank word
      end
      ST_RSEL: begin
        eng_rd   = (row != rank_row);
        eng_addr = word_addr(row, col_block);
      end
      ST_XRDP: begin
        eng_rd   = 1'b1;
        eng_addr = word_addr(rank_row, blk);
      end
      ST_XRDT: begin
        eng_rd   = 1'b1;
        eng_addr = word_addr(row, blk);
      end
      ST_XWR: begin
        eng_wr    = 1'b1;
        eng_addr  = word_addr(row, blk);
        eng_wdata = eng_rdata ^ hold;  // gf(2) row add
      end
      default: ;
    endcase
  end

endmodule

// File: hdl/matrix_mem.sv
// matrix word store with registered read, engine owns it while busy, external port otherwise
module matrix_mem (
  input  logic                         clk,
  input  logic                         busy,
  input  logic                         rd_en,
  input  logic                         wr_en,
  input  logic [gauss_pkg::ADDR_W-1:0] rd_addr,
  input  logic [gauss_pkg::ADDR_W-1:0] wr_addr,
  input  logic [gauss_pkg::N-1:0]      data_in,
  output logic [gauss_pkg::N-1:0]      data_out,
  input  logic                         eng_rd,
  input  logic                         eng_wr,
  input  logic [gauss_pkg::ADDR_W-1:0] eng_addr,
  input  logic [gauss_pkg::N-1:0]      eng_wdata,
  output logic [gauss_pkg::N-1:0]      eng_rdata
);
  import gauss_pkg::*;

  logic [N-1:0]      mem [L*BLOCKS];  // one word per row block
  logic [N-1:0]      rd_q;            // shared read register
  logic              r_en;
  logic              w_en;
  logic [ADDR_W-1:0] r_addr;
  logic [ADDR_W-1:0] w_addr;
  logic [N-1:0]      w_data;

  // busy picks the engine, external strobes are dropped meanwhile
  assign r_en   = busy ? eng_rd    : rd_en;
  assign w_en   = busy ? eng_wr    : wr_en;
  assign r_addr = busy ? eng_addr  : rd_addr;
  assign w_addr = busy ? eng_addr  : wr_addr;
  assign w_data = busy ? eng_wdata : data_in;

  always_ff @(posedge clk) begin
    if (w_en)
      mem[w_addr] <= w_data;
    if (r_en)
      rd_q <= mem[r_addr];  // old data on same-address write
  end

  assign data_out  = rd_q;
  assign eng_rdata = rd_q;

endmodule

// File: hdl/gauss_pkg.sv
// matrix dimensions, derived widths and step engine state codes, imported by every gf(2) block
package gauss_pkg;

  localparam int N      = 4;                   // bits per word = columns per block
  localparam int L      = 8;                   // rows
  localparam int K      = 16;                  // columns
  localparam int BLOCKS = K / N;               // column blocks per row
  // word address is row*BLOCKS + block, bit j of a word is column block*N + j
  localparam int ADDR_W = $clog2(L * BLOCKS);
  localparam int BLK_W  = $clog2(BLOCKS + 1);  // holds 0..BLOCKS
  localparam int ROW_W  = $clog2(L);
  localparam int RANK_W = $clog2(L + 1);       // holds 0..L

  // elim_step fsm encoding
  localparam int ST_W = 4;
  localparam logic [ST_W-1:0] ST_IDLE = 4'd0;
  localparam logic [ST_W-1:0] ST_COL  = 4'd1;   // column setup
  localparam logic [ST_W-1:0] ST_SRD  = 4'd2;   // search read
  localparam logic [ST_W-1:0] ST_SCHK = 4'd3;   // search test
  localparam logic [ST_W-1:0] ST_WRDA = 4'd4;   // swap, read rank row
  localparam logic [ST_W-1:0] ST_WRDB = 4'd5;   // swap, read pivot row
  localparam logic [ST_W-1:0] ST_WWRA = 4'd6;   // swap, write rank row
  localparam logic [ST_W-1:0] ST_WWRB = 4'd7;   // swap, write pivot row
  localparam logic [ST_W-1:0] ST_RSEL = 4'd8;   // reduce, read target col word
  localparam logic [ST_W-1:0] ST_RCHK = 4'd9;   // reduce, test target bit
  localparam logic [ST_W-1:0] ST_XRDP = 4'd10;  // xor, read pivot word
  localparam logic [ST_W-1:0] ST_XRDT = 4'd11;  // xor, read target word
  localparam logic [ST_W-1:0] ST_XWR  = 4'd12;  // xor, write back
  localparam logic [ST_W-1:0] ST_RNXT = 4'd13;  // reduce, next row
  localparam logic [ST_W-1:0] ST_NEXT = 4'd14;  // next column

endpackage
